// ==== src/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`define FQ_DEPTH 4    // fetch queue entries
`define XLEN     32   // data and address width

`endif

// ==== src/rvPkg.sv ====
package rvPkg;

    // major opcodes handled by the front end
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111
    } rvOpcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        rvOpcode_e  opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm;       // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        rvOpcode_e   opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0] immHi;      // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;      // imm[4:0]
        rvOpcode_e  opcode;
    } sType_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;      // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;      // imm[4:1]
        logic       imm11;
        rvOpcode_e  opcode;
    } bType_s;

    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;      // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;      // imm[19:12]
        logic [4:0] rd;
        rvOpcode_e  opcode;
    } jType_s;

    // one instruction word, five format views
    typedef union packed {
        rType_s rType;
        iType_s iType;
        sType_s sType;
        bType_s bType;
        jType_s jType;
    } rvInstr_u;

    typedef enum logic [1:0] {WB_ALU = 2'd0, WB_MEM = 2'd1, WB_PC4 = 2'd2, WB_IMM = 2'd3} wbSel_e;
    typedef enum logic [1:0] {B_RS2 = 2'd0, B_IIMM = 2'd1, B_SIMM = 2'd2, B_UIMM = 2'd3} bSel_e;
    typedef enum logic [1:0] {PC_SEQ = 2'd0, PC_BR = 2'd1, PC_JAL = 2'd2, PC_JALR = 2'd3} pcSel_e;

endpackage

// ==== src/fetchUnit.sv ====
`include "frontend_config.svh"

module fetchUnit (
    input  logic               clk,
    input  logic               nrst,
    output logic               wbCyc,        // bus cycle active
    output logic               wbStb,        // strobe, tied to cycle here
    output logic [`XLEN-1:0]   wbAdr,        // fetch address
    input  logic [`XLEN-1:0]   wbDatI,       // instruction word from memory
    input  logic               wbAck,        // memory done
    input  logic               full,         // queue has no room
    output logic               push,         // write one entry into queue
    output logic [`XLEN-1:0]   pushPc,
    output rvPkg::rvInstr_u    pushInstr
);

    logic             busy;                  // idle=0, busy=1
    logic [`XLEN-1:0] pc;                    // address of word in flight
    logic             ackSeen;               // ack during our own cycle

    assign ackSeen = busy && wbAck;

    // bus follows the state directly
    assign wbCyc = busy;
    assign wbStb = busy;
    assign wbAdr = pc;

    // word goes straight to the queue on the ack edge
    assign push      = ackSeen;
    assign pushPc    = pc;
    assign pushInstr = wbDatI;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            busy <= 1'b0;
            pc   <= `RESET_PC;
        end
        else if (ackSeen)
        begin
            busy <= 1'b0;                    // drop cyc/stb for at least one cycle
            pc   <= pc + `XLEN'(4);          // purely sequential fetch
        end
        else if (!busy && !full)
        begin
            busy <= 1'b1;                    // room in queue, start next read
        end
    end

    // classic handshake, master may not change its request before ack
    property reqHold;
        @(posedge clk) disable iff (!nrst)
            (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr));
    endproperty
    assert property (reqHold)
        else $error("fetchUnit: stb or address changed before ack");

endmodule

// ==== src/fetchQueue.sv ====
`include "frontend_config.svh"

module fetchQueue (
    input  logic             clk,
    input  logic             nrst,
    input  logic             push,
    input  logic [`XLEN-1:0] pushPc,
    input  rvPkg::rvInstr_u  pushInstr,
    input  logic             pop,
    output logic [`XLEN-1:0] headPc,      // oldest entry, valid while !empty
    output rvPkg::rvInstr_u  headInstr,
    output logic             full,
    output logic             empty
);
    import rvPkg::*;

    localparam int DEPTH = `FQ_DEPTH;
    localparam int PW    = $clog2(DEPTH);      // pointer width
    localparam int CW    = $clog2(DEPTH + 1);  // count width, holds DEPTH

    logic [`XLEN-1:0] pcMem [DEPTH];           // payload, no reset
    rvInstr_u         instrMem [DEPTH];
    logic [PW-1:0]    wrPtr, rdPtr;
    logic [CW-1:0]    count;

    assign full      = (count == CW'(DEPTH));
    assign empty     = (count == '0);
    assign headPc    = pcMem[rdPtr];           // fall through, no read latency
    assign headInstr = instrMem[rdPtr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            pcMem[wrPtr]    <= pushPc;
            instrMem[wrPtr] <= pushInstr;
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= (wrPtr == PW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;   // wrap
            if (pop)
                rdPtr <= (rdPtr == PW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // fetch gating and decode load condition must keep these away
    assert property (@(posedge clk) disable iff (!nrst) !(push && full))
        else $error("fetchQueue: push while full");
    assert property (@(posedge clk) disable iff (!nrst) !(pop && empty))
        else $error("fetchQueue: pop while empty");

endmodule

// ==== src/instrDecoder.sv ====
module instrDecoder (
    input  rvPkg::rvOpcode_e op,
    input  logic [2:0]       funct3,
    input  logic             instr30,    // sub/sra select
    output logic             regWe,      // register file write enable
    output logic [3:0]       aluFn,      // {instr30, funct3} style code
    output rvPkg::bSel_e     bSel,       // operand b source
    output rvPkg::wbSel_e    wbSel,      // write-back source
    output rvPkg::pcSel_e    pcSel,      // next pc source, reported only
    output logic             bneq,       // bne-style branch
    output logic             illegal
);
    import rvPkg::*;

    always_comb
    begin
        // defaults cover the don't-care fields
        regWe   = 1'b0;
        aluFn   = 4'd0;
        bSel    = B_RS2;
        wbSel   = WB_ALU;
        pcSel   = PC_SEQ;
        bneq    = 1'b0;
        illegal = 1'b0;
        case (op)
            OP:
            begin
                regWe = 1'b1;
                aluFn = {instr30, funct3};
            end
            OPIMM:
            begin
                regWe = 1'b1;
                bSel  = B_IIMM;
                // srli/srai need bit 30, the rest ignore it
                aluFn = (funct3 == 3'b101) ? {instr30, funct3} : {1'b0, funct3};
            end
            LOAD:
            begin
                regWe = 1'b1;
                bSel  = B_IIMM;
                wbSel = WB_MEM;
            end
            STORE:
                bSel  = B_SIMM;              // no write back
            BRANCH:
            begin
                pcSel = PC_BR;
                bneq  = funct3[0];           // bne/bge/bgeu invert the compare
            end
            JAL:
            begin
                regWe = 1'b1;
                wbSel = WB_PC4;              // link address
                pcSel = PC_JAL;
            end
            JALR:
            begin
                regWe = 1'b1;
                bSel  = B_IIMM;
                wbSel = WB_PC4;
                pcSel = PC_JALR;
            end
            LUI:
            begin
                regWe = 1'b1;
                bSel  = B_UIMM;
                wbSel = WB_IMM;
            end
            default:
                illegal = 1'b1;              // regWe stays low
        endcase
    end

endmodule

// ==== src/decodeStage.sv ====
`include "frontend_config.svh"

module decodeStage (
    input  logic             clk,
    input  logic             nrst,
    input  logic [`XLEN-1:0] headPc,
    input  rvPkg::rvInstr_u  headInstr,
    input  logic             empty,
    output logic             pop,         // same cycle as register load
    output logic             decValid,
    input  logic             decReady,
    output logic [`XLEN-1:0] pc,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic [4:0]       shamt,
    output logic [`XLEN-1:0] iImm,
    output logic [`XLEN-1:0] sImm,
    output logic [`XLEN-1:0] bImm,
    output logic [`XLEN-1:0] jImm,
    output logic [`XLEN-1:0] uImm,
    output logic             regWe,
    output logic [3:0]       aluFn,
    output rvPkg::bSel_e     bSel,
    output rvPkg::wbSel_e    wbSel,
    output rvPkg::pcSel_e    pcSel,
    output logic             bneq,
    output logic             illegal
);
    import rvPkg::*;

    rvInstr_u         instrReg;            // payload, loaded with pop
    logic [`XLEN-1:0] pcReg;
    logic             load;

    // take a new entry when the slot is free or being drained
    assign load = !empty && (!decValid || decReady);
    assign pop  = load;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
            decValid <= 1'b0;
        else if (load)
            decValid <= 1'b1;
        else if (decReady)
            decValid <= 1'b0;              // accepted, nothing behind it
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            instrReg <= headInstr;
            pcReg    <= headPc;
        end
    end

    // register fields
    assign pc    = pcReg;
    assign rs1   = instrReg.rType.rs1;
    assign rs2   = instrReg.rType.rs2;
    assign rd    = instrReg.rType.rd;
    assign shamt = instrReg.iType.imm[4:0];

    // immediates, sign extended from each format view
    assign iImm = `XLEN'($signed(instrReg.iType.imm));
    assign sImm = `XLEN'($signed({instrReg.sType.immHi, instrReg.sType.immLo}));
    assign bImm = `XLEN'($signed({instrReg.bType.imm12, instrReg.bType.imm11,
                                  instrReg.bType.immHi, instrReg.bType.immLo, 1'b0}));
    assign jImm = `XLEN'($signed({instrReg.jType.imm20, instrReg.jType.immHi,
                                  instrReg.jType.imm11, instrReg.jType.immLo, 1'b0}));
    assign uImm = {instrReg[31:12], 12'b0};    // upper 20 bits, low zeros

    instrDecoder decoder (
        .op      (instrReg.rType.opcode),
        .funct3  (instrReg.rType.funct3),
        .instr30 (instrReg.rType.funct7[5]),   // bit 30 of the word
        .regWe   (regWe),
        .aluFn   (aluFn),
        .bSel    (bSel),
        .wbSel   (wbSel),
        .pcSel   (pcSel),
        .bneq    (bneq),
        .illegal (illegal)
    );

    // stalled result must not move
    property holdOnStall;
        @(posedge clk) disable iff (!nrst)
            (decValid && !decReady) |=> (decValid && $stable(instrReg) && $stable(pcReg));
    endproperty
    assert property (holdOnStall)
        else $error("decodeStage: outputs changed while stalled");

endmodule

// ==== src/frontendTop.sv ====
`include "frontend_config.svh"

module frontendTop (
    input  logic             clk,
    input  logic             nrst,
    output logic             wbCyc,
    output logic             wbStb,
    output logic [`XLEN-1:0] wbAdr,
    input  logic [`XLEN-1:0] wbDatI,
    input  logic             wbAck,
    output logic             decValid,
    input  logic             decReady,
    output logic [`XLEN-1:0] pc,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic [4:0]       shamt,
    output logic [`XLEN-1:0] iImm,
    output logic [`XLEN-1:0] sImm,
    output logic [`XLEN-1:0] bImm,
    output logic [`XLEN-1:0] jImm,
    output logic [`XLEN-1:0] uImm,
    output logic             regWe,
    output logic [3:0]       aluFn,
    output rvPkg::bSel_e     bSel,
    output rvPkg::wbSel_e    wbSel,
    output rvPkg::pcSel_e    pcSel,
    output logic             bneq,
    output logic             illegal
);
    import rvPkg::*;

    logic             full, empty;         // queue status
    logic             push, pop;
    logic [`XLEN-1:0] pushPc, headPc;
    rvInstr_u         pushInstr, headInstr;

    fetchUnit fetch (
        .clk       (clk),
        .nrst      (nrst),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbAdr     (wbAdr),
        .wbDatI    (wbDatI),
        .wbAck     (wbAck),
        .full      (full),
        .push      (push),
        .pushPc    (pushPc),
        .pushInstr (pushInstr)
    );

    fetchQueue queue (
        .clk       (clk),
        .nrst      (nrst),
        .push      (push),
        .pushPc    (pushPc),
        .pushInstr (pushInstr),
        .pop       (pop),
        .headPc    (headPc),
        .headInstr (headInstr),
        .full      (full),
        .empty     (empty)
    );

    decodeStage decode (
        .clk       (clk),
        .nrst      (nrst),
        .headPc    (headPc),
        .headInstr (headInstr),
        .empty     (empty),
        .pop       (pop),
        .decValid  (decValid),
        .decReady  (decReady),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .shamt     (shamt),
        .iImm      (iImm),
        .sImm      (sImm),
        .bImm      (bImm),
        .jImm      (jImm),
        .uImm      (uImm),
        .regWe     (regWe),
        .aluFn     (aluFn),
        .bSel      (bSel),
        .wbSel     (wbSel),
        .pcSel     (pcSel),
        .bneq      (bneq),
        .illegal   (illegal)
    );

endmodule

// ==== tests/tbClock.sv ====
module tbClock (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;           // 10 ns period
    end

    initial
    begin
        nrst = 1'b0;
        repeat (8) @(posedge clk);       // reset held for 8 cycles
        nrst <= 1'b1;
    end

endmodule

// ==== tests/frontendChecker.sv ====
`include "frontend_config.svh"

module frontendChecker #(
    parameter int WORDS = 256
) (
    input  logic             clk,
    input  logic             nrst,
    input  logic             wbCyc,
    input  logic             wbStb,
    input  logic [`XLEN-1:0] wbAdr,
    input  logic             wbAck,
    input  logic             decValid,
    input  logic             decReady,
    input  logic [`XLEN-1:0] pc,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       rd,
    input  logic [4:0]       shamt,
    input  logic [`XLEN-1:0] iImm,
    input  logic [`XLEN-1:0] sImm,
    input  logic [`XLEN-1:0] bImm,
    input  logic [`XLEN-1:0] jImm,
    input  logic [`XLEN-1:0] uImm,
    input  logic             regWe,
    input  logic [3:0]       aluFn,
    input  logic [1:0]       bSel,
    input  logic [1:0]       wbSel,
    input  logic [1:0]       pcSel,
    input  logic             bneq,
    input  logic             illegal,
    output bit               done,
    output int               checks,
    output int               errors
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [4:0]  rs1, rs2, rd, shamt;
        logic [31:0] iImm, sImm, bImm, jImm, uImm;
        logic        regWe;
        logic [3:0]  aluFn;
        logic [1:0]  bSel, wbSel, pcSel;
        logic        bneq, illegal;
        logic        bSelCare, wbSelCare;    // cleared where the field is free
    } expect_t;

    int           testErr [1:5];             // errors per test
    int           accepted, fetched;         // results taken, words acked
    int           beqSeen, bneSeen;
    bit           resetChecked, firstSeen;
    logic         prevCyc, prevStb, prevAck, prevValid, prevReady;
    logic [31:0]  prevAdr;
    logic [224:0] outBus, heldBus;           // every decode output side by side

    assign errors = testErr[1] + testErr[2] + testErr[3] + testErr[4] + testErr[5];
    assign outBus = {pc, rs1, rs2, rd, shamt, iImm, sImm, bImm, jImm, uImm,
                     regWe, aluFn, bSel, wbSel, pcSel, bneq, illegal};

    // expected decode of one word, straight from the RV32I encodings
    function automatic expect_t refDecode(input logic [31:0] w);
        expect_t    e;
        logic [2:0] f3;
        f3 = w[14:12];
        e = '0;
        e.bSelCare  = 1'b1;
        e.wbSelCare = 1'b1;
        e.rs1   = w[19:15];
        e.rs2   = w[24:20];
        e.rd    = w[11:7];
        e.shamt = w[24:20];
        e.iImm  = {{20{w[31]}}, w[31:20]};
        e.sImm  = {{20{w[31]}}, w[31:25], w[11:7]};
        e.bImm  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.jImm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e.uImm  = {w[31:12], 12'b0};
        case (w[6:0])
            7'b0110011:                      // op
            begin
                e.regWe = 1'b1;
                e.aluFn = {w[30], f3};
            end
            7'b0010011:                      // op-imm, bit 30 only for right shifts
            begin
                e.regWe = 1'b1;
                e.bSel  = 2'd1;
                e.aluFn = (f3 == 3'b101) ? {w[30], f3} : {1'b0, f3};
            end
            7'b0000011:                      // load
            begin
                e.regWe = 1'b1;
                e.bSel  = 2'd1;
                e.wbSel = 2'd1;
            end
            7'b0100011:                      // store
            begin
                e.bSel      = 2'd2;
                e.wbSelCare = 1'b0;
            end
            7'b1100011:                      // branch
            begin
                e.pcSel     = 2'd1;
                e.bneq      = f3[0];
                e.wbSelCare = 1'b0;
            end
            7'b1101111:                      // jal
            begin
                e.regWe    = 1'b1;
                e.wbSel    = 2'd2;
                e.pcSel    = 2'd2;
                e.bSelCare = 1'b0;
            end
            7'b1100111:                      // jalr
            begin
                e.regWe = 1'b1;
                e.bSel  = 2'd1;
                e.wbSel = 2'd2;
                e.pcSel = 2'd3;
            end
            7'b0110111:                      // lui
            begin
                e.regWe = 1'b1;
                e.bSel  = 2'd3;
                e.wbSel = 2'd3;
            end
            default:
            begin
                e.illegal   = 1'b1;
                e.bSelCare  = 1'b0;
                e.wbSelCare = 1'b0;
            end
        endcase
        return e;
    endfunction

    task automatic compareField(input string name, input logic [31:0] expV,
                                input logic [31:0] actV, input int testNo);
        checks++;
        if (expV !== actV)
        begin
            $display("FAILED %s: expected %h, actual %h at pc %h", name, expV, actV, pc);
            testErr[testNo]++;
        end
    endtask

    task automatic reportTest(input int n, input string what);
        $display("test %0d %s: %s, %0d errors", n, what,
                 (testErr[n] == 0) ? "ok" : "failed", testErr[n]);
    endtask

    always @(posedge clk)
    begin
        expect_t     want;
        logic [31:0] word;
        if (!nrst)
        begin
            prevCyc   = 1'b0;
            prevStb   = 1'b0;
            prevAck   = 1'b0;
            prevValid = 1'b0;
            prevReady = 1'b0;
        end
        else if (!done)
        begin
            if (!resetChecked)
            begin
                compareField("wbCyc", 32'd0, wbCyc, 1);     // first edge out of reset
                compareField("wbStb", 32'd0, wbStb, 1);
                compareField("decValid", 32'd0, decValid, 1);
                resetChecked = 1'b1;
            end
            if (!firstSeen && wbCyc)
            begin
                compareField("wbAdr", `RESET_PC, wbAdr, 1);
                firstSeen = 1'b1;
                reportTest(1, "reset state and first fetch address");
            end

            // bus protocol
            if (prevStb && !prevAck)
            begin
                compareField("wbStb", 32'd1, wbStb, 5);
                compareField("wbAdr", prevAdr, wbAdr, 5);
            end
            if (prevCyc && prevAck)
                compareField("wbCyc", 32'd0, wbCyc, 5);     // idle cycle after ack
            if (wbCyc && !prevCyc)
            begin
                checks++;
                if (fetched - accepted - int'(decValid) >= `FQ_DEPTH)
                begin
                    $display("bus cycle started with %0d words already queued",
                             fetched - accepted - int'(decValid));
                    testErr[5]++;
                end
            end

            // stalled result
            if (prevValid && !prevReady)
            begin
                compareField("decValid", 32'd1, decValid, 5);
                checks++;
                if (outBus !== heldBus)
                begin
                    $display("FAILED decode outputs: expected %h, actual %h", heldBus, outBus);
                    testErr[5]++;
                end
            end

            // accepted result against memory
            if (decValid && decReady)
            begin
                word = frontendTb.progMem[accepted];
                want = refDecode(word);
                compareField("pc", `RESET_PC + 32'(accepted * 4), pc, 2);
                compareField("rs1", want.rs1, rs1, 3);
                compareField("rs2", want.rs2, rs2, 3);
                compareField("rd", want.rd, rd, 3);
                compareField("shamt", want.shamt, shamt, 3);
                compareField("iImm", want.iImm, iImm, 3);
                compareField("sImm", want.sImm, sImm, 3);
                compareField("bImm", want.bImm, bImm, 3);
                compareField("jImm", want.jImm, jImm, 3);
                compareField("uImm", want.uImm, uImm, 3);
                compareField("regWe", want.regWe, regWe, 4);
                compareField("aluFn", want.aluFn, aluFn, 4);
                if (want.bSelCare)
                    compareField("bSel", want.bSel, bSel, 4);
                if (want.wbSelCare)
                    compareField("wbSel", want.wbSel, wbSel, 4);
                compareField("pcSel", want.pcSel, pcSel, 4);
                compareField("bneq", want.bneq, bneq, 4);
                compareField("illegal", want.illegal, illegal, 4);
                if (word[6:0] == 7'b1100011)
                begin
                    if (word[12])
                        bneSeen++;
                    else
                        beqSeen++;
                end
                accepted++;
                if (accepted == WORDS)
                begin
                    if (beqSeen == 0 || bneSeen == 0)
                    begin
                        $display("branches with bneq 0 and 1 were not both decoded");
                        testErr[4]++;
                    end
                    reportTest(2, "in-order pc sequence");
                    reportTest(3, "register fields and immediates");
                    reportTest(4, "control fields per opcode class");
                    reportTest(5, "stall hold and bus protocol");
                    done <= 1'b1;
                end
            end
            if (wbCyc && wbAck)
                fetched++;

            prevCyc   = wbCyc;
            prevStb   = wbStb;
            prevAck   = wbAck;
            prevAdr   = wbAdr;
            prevValid = decValid;
            prevReady = decReady;
            heldBus   = outBus;
        end
    end

endmodule

// ==== tests/frontendTb.sv ====
`include "frontend_config.svh"

module frontendTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WORDS   = 256;
    localparam int TIMEOUT = WORDS * 16 + 100;    // worst case per word plus slack

    logic             clk, nrst;
    logic             wbCyc, wbStb;
    logic [`XLEN-1:0] wbAdr;
    logic [`XLEN-1:0] wbDatI = '0;
    logic             wbAck = 1'b0;
    logic             decValid;
    logic             decReady = 1'b0;
    logic [`XLEN-1:0] pc;
    logic [4:0]       rs1, rs2, rd, shamt;
    logic [`XLEN-1:0] iImm, sImm, bImm, jImm, uImm;
    logic             regWe;
    logic [3:0]       aluFn;
    logic [1:0]       bSel, wbSel, pcSel;
    logic             bneq, illegal;
    bit               done;                       // checker saw all words
    int               checks, errors;
    int               cycleCount;

    logic [31:0]      progMem [WORDS];            // instruction memory image
    logic [31:0]      rngState = 32'hb4f5;
    logic [1:0]       waitLeft;                   // wait states before next ack
    logic [4:0]       readyLeft;                  // cycles before the next ready draw

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRandom(output logic [31:0] r);
        rngState = xorshift32(rngState);
        r = rngState;
    endtask

    tbClock clockGen (.clk(clk), .nrst(nrst));

    frontendTop uut (.*);

    frontendChecker #(.WORDS(WORDS)) check (.*);

    // random program, one opcode per word from the handled set or fence
    initial
    begin : fillProgram
        logic [31:0] pick, body;
        logic [6:0]  opc;
        for (int i = 0; i < WORDS; i++)
        begin
            nextRandom(pick);
            nextRandom(body);
            case (pick % 9)
                0: opc = 7'b0000011;              // load
                1: opc = 7'b0100011;              // store
                2: opc = 7'b0010011;              // op-imm
                3: opc = 7'b0110011;              // op
                4: opc = 7'b1100011;              // branch
                5: opc = 7'b1101111;              // jal
                6: opc = 7'b1100111;              // jalr
                7: opc = 7'b0110111;              // lui
                default: opc = 7'b0001111;        // fence, not decoded here
            endcase
            progMem[i] = {body[31:7], opc};
        end
        // a beq and a bne at fixed spots so both bneq values show up
        progMem[4] = {progMem[4][31:15], 3'b000, progMem[4][11:7], 7'b1100011};
        progMem[5] = {progMem[5][31:15], 3'b001, progMem[5][11:7], 7'b1100011};
        nextRandom(pick);
        waitLeft = pick[1:0];
    end

    // wishbone slave model and random ready
    always @(posedge clk)
    begin
        logic [31:0] r;
        if (!nrst)
        begin
            wbAck     <= 1'b0;
            decReady  <= 1'b0;
            readyLeft = 5'd0;
        end
        else
        begin
            if (readyLeft == 5'd0)
            begin
                nextRandom(r);
                decReady <= (r % 100) < 70;       // ready 70% of cycles
                nextRandom(r);
                readyLeft = r[4:0];               // held 1 to 32 cycles, long lows fill the queue
            end
            else
                readyLeft = readyLeft - 5'd1;
            if (wbAck)
                wbAck <= 1'b0;                    // single cycle ack
            else if (wbCyc && wbStb)
            begin
                if (waitLeft == 2'd0)
                begin
                    wbAck  <= 1'b1;
                    wbDatI <= progMem[wbAdr[9:2]];   // word address, wraps at 256
                    nextRandom(r);
                    waitLeft = r[1:0];            // 0 to 3 waits for the next one
                end
                else
                    waitLeft = waitLeft - 2'd1;
            end
        end
    end

    // run control and cycle limit
    initial
    begin
        cycleCount = 0;
        while (!done && cycleCount < TIMEOUT)
        begin
            @(posedge clk);
            cycleCount++;
        end
        if (!done)
            $display("timeout after %0d cycles, only %0d of %0d results accepted",
                     cycleCount, check.accepted, WORDS);
        $display("%0d checks, %0d errors, %0d cycles", checks, errors, cycleCount);
        if (done && errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+src
src/rvPkg.sv
src/fetchUnit.sv
src/fetchQueue.sv
src/instrDecoder.sv
src/decodeStage.sv
src/frontendTop.sv
tests/tbClock.sv
tests/frontendChecker.sv
tests/frontendTb.sv
